// File: Makefile
# Verilator simulation of the accelerator completion path

VERILATOR ?= verilator
TOP       ?= accel_tb
FILELIST  ?= accel_done.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

# Pass or fail is taken from the log, not from the exit code
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: accel_done.f
hw/afu_pkg.sv
hw/job_if.sv
hw/cmd_intake.sv
hw/sum_sq_engine.sv
hw/soft_reset_seq.sv
hw/done_control.sv
hw/status_reporter.sv
hw/accel_top.sv
tb/tb_clock.sv
tb/accel_assert.sv
tb/accel_tb.sv

// File: hw/accel_top.sv
/*
 * Accelerator completion path top
 * Command intake, sum of squares engine, soft reset
 * sequencer, done controller and status reporter
 */
`timescale 1ns/1ps

module accel_top (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         cmd_req,
	input  afu_pkg::cmd_op_t             cmd_op,
	input  logic [31:0]                  cmd_data,
	output logic                         cmd_ack,
	output logic                         status_req,
	input  logic                         status_ack,
	output logic [afu_pkg::STATUS_W-1:0] status_data,
	output logic                         busy
);
	import afu_pkg::*;

	logic                soft_rstn;
	logic                enabled;
	logic                reset_done;
	logic                report_req;
	logic                report_ack;
	logic [STATUS_W-1:0] report_status;

	job_if job_bus ();

	//////////////////////
	// Input side
	//////////////////////

	cmd_intake u_intake (
		.clock, .rstn, .soft_rstn,
		.cmd_req, .cmd_op, .cmd_data, .cmd_ack,
		.enabled, .busy,
		.report_done (report_ack),
		.job         (job_bus)
	);

	//////////////////////
	// Processing
	//////////////////////

	sum_sq_engine u_engine (.clock, .rstn, .soft_rstn, .job(job_bus));

	soft_reset_seq u_soft_rst (.clock, .rstn, .reset_done, .soft_rstn);

	// Status word is tag, length, sum
	done_control u_done (
		.clock, .rstn, .soft_rstn,
		.enabled_in       (enabled),
		.algorithm_status ({job_bus.tag, job_bus.length, job_bus.result}),
		.algorithm_done   (job_bus.done),
		.report_ack, .reset_done, .report_req, .report_status
	);

	//////////////////////
	// Output side
	//////////////////////

	status_reporter u_reporter (
		.clock, .rstn,
		.report_req, .report_status, .report_ack,
		.status_req, .status_ack, .status_data
	);

endmodule

// File: hw/afu_pkg.sv
/*
 * AFU shared definitions
 * Status word width, soft reset pulse length,
 * host command opcodes and completion FSM states
 */
package afu_pkg;

	//////////////////////
	// Widths and timing
	//////////////////////

	// Status word handed to the host, MSB first
	//   63..48 job tag
	//   47..32 job length N
	//   31..0  sum of k*k for k = 1..N, mod 2^32
	localparam int STATUS_W = 64;

	// Cycles soft_rstn is held low per completion
	localparam int SOFT_RST_CYCLES = 4;
	// Counter wide enough for the soft reset count
	localparam int SOFT_CNT_W = $clog2(SOFT_RST_CYCLES + 1);

	//////////////////////
	// Enumerations
	//////////////////////

	// Host command opcodes on cmd_op
	typedef enum logic [1:0] {
		CMD_NOP     = 2'd0,
		CMD_ENABLE  = 2'd1,
		CMD_DISABLE = 2'd2,
		CMD_START   = 2'd3
	} cmd_op_t;

	// Done controller states
	typedef enum logic [2:0] {
		DONE_RESET, DONE_IDLE, DONE_RESET_REQ, DONE_RESET_PENDING, DONE_MMIO_REQ
	} done_state;

endpackage

// File: hw/cmd_intake.sv
/*
 * Command intake
 * Four-phase req/ack from the host, opcode decode,
 * completion enable and busy tracking for one job
 */
`timescale 1ns/1ps

module cmd_intake (
	input  logic             clock,
	input  logic             rstn,
	input  logic             soft_rstn,
	input  logic             cmd_req,
	input  afu_pkg::cmd_op_t cmd_op,
	input  logic [31:0]      cmd_data,
	output logic             cmd_ack,
	output logic             enabled,
	output logic             busy,
	input  logic             report_done,
	job_if.intake_mp         job
);
	import afu_pkg::*;

	logic accept;
	logic start_ok;

	// New command seen, ack still low
	assign accept = cmd_req & ~cmd_ack;
	// A start only takes while idle and engine out of soft reset
	assign start_ok = accept && (cmd_op == CMD_START) && !busy && soft_rstn;

	//////////////////////
	// Handshake
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_ack <= 1'b0;
		end else if (accept) begin
			cmd_ack <= 1'b1;
		end else if (!cmd_req) begin
			// Host released req
			cmd_ack <= 1'b0;
		end
	end

	//////////////////////
	// Decode
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled   <= 1'b0;
			busy      <= 1'b0;
			job.start <= 1'b0;
			job.clear <= 1'b0;
		end else begin
			job.start <= 1'b0;
			job.clear <= 1'b0;
			if (accept && cmd_op == CMD_ENABLE)
				enabled <= 1'b1;
			if (accept && cmd_op == CMD_DISABLE)
				enabled <= 1'b0;
			// START while busy is acked and dropped
			if (start_ok) begin
				busy      <= 1'b1;
				job.start <= 1'b1;
			end
			// Report delivered, job slot free again
			if (report_done) begin
				busy      <= 1'b0;
				job.clear <= 1'b1;
			end
		end
	end

	// Tag in the upper half, length in the lower
	always_ff @(posedge clock) begin
		if (start_ok) begin
			job.tag    <= cmd_data[31:16];
			job.length <= cmd_data[15:0];
		end
	end

endmodule

// File: hw/done_control.sv
/*
 * Done controller
 * On job done, request a soft reset, wait for soft_rstn
 * to come back, then hand the latched status to the reporter
 */
`timescale 1ns/1ps

module done_control (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         soft_rstn,
	input  logic                         enabled_in,
	input  logic [afu_pkg::STATUS_W-1:0] algorithm_status,
	input  logic                         algorithm_done,
	input  logic                         report_ack,
	output logic                         reset_done,
	output logic                         report_req,
	output logic [afu_pkg::STATUS_W-1:0] report_status
);
	import afu_pkg::*;

	done_state             current_state;
	done_state             next_state;
	logic                  enabled;
	logic                  done_reg;
	logic [STATUS_W-1:0]   status_latched;
	logic                  soft_rstn_s1;
	logic                  soft_rstn_s2;
	logic                  soft_rstn_rise;

	//////////////////////
	// Input registers
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled        <= 1'b0;
			done_reg       <= 1'b0;
			soft_rstn_s1   <= 1'b1;
			soft_rstn_s2   <= 1'b1;
			soft_rstn_rise <= 1'b0;
		end else begin
			enabled        <= enabled_in;
			done_reg       <= algorithm_done;
			// Two stage sync, then edge detect
			soft_rstn_s1   <= soft_rstn;
			soft_rstn_s2   <= soft_rstn_s1;
			soft_rstn_rise <= soft_rstn_s1 & ~soft_rstn_s2;
		end
	end

	//////////////////////
	// Completion FSM
	//////////////////////

	// Whole controller frozen while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			current_state <= DONE_RESET;
		else if (enabled)
			current_state <= next_state;
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			DONE_RESET:         next_state = DONE_IDLE;
			DONE_IDLE:          if (done_reg) next_state = DONE_RESET_REQ;
			DONE_RESET_REQ:     next_state = DONE_RESET_PENDING;
			DONE_RESET_PENDING: if (soft_rstn_rise) next_state = DONE_MMIO_REQ;
			DONE_MMIO_REQ:      if (report_ack) next_state = DONE_IDLE;
			default:            next_state = DONE_RESET;
		endcase
	end

	// Track the engine status until the job finishes
	always_ff @(posedge clock) begin
		if (enabled && current_state == DONE_IDLE)
			status_latched <= algorithm_status;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			reset_done    <= 1'b1;
			report_status <= '0;
		end else if (enabled) begin
			// reset_done low only for the cycle after RESET_REQ
			reset_done <= (current_state != DONE_RESET_REQ);
			// Follows the latched status, which freezes once done is seen
			if (current_state == DONE_RESET)
				report_status <= '0;
			else
				report_status <= status_latched;
		end
	end

	// All-zero status means nothing to report
	assign report_req = (current_state == DONE_MMIO_REQ) && (report_status != '0);

endmodule

// File: hw/job_if.sv
/*
 * Job interface
 * Start, parameters, result and done between
 * the command intake and the sum of squares engine
 */
`timescale 1ns/1ps

interface job_if;
	// One cycle start pulse, intake to engine
	logic        start;
	// Job parameters, stable while busy
	logic [15:0] tag;
	logic [15:0] length;
	// Engine result, held with done
	logic [31:0] result;
	logic        done;
	// One cycle pulse once the status has been reported
	logic        clear;

	modport intake_mp (
		output start, tag, length, clear,
		input  result, done
	);

	modport engine_mp (
		input  start, length, clear,
		output result, done
	);
endinterface

// File: hw/soft_reset_seq.sv
/*
 * Soft reset sequencer
 * Fixed-length soft_rstn low pulse on each
 * falling edge of reset_done
 */
`timescale 1ns/1ps

module soft_reset_seq (
	input  logic clock,
	input  logic rstn,
	input  logic reset_done,
	output logic soft_rstn
);
	import afu_pkg::*;

	logic                  reset_done_q;
	logic [SOFT_CNT_W-1:0] count;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			reset_done_q <= 1'b1;
			soft_rstn    <= 1'b1;
			count        <= '0;
		end else begin
			reset_done_q <= reset_done;
			if (!soft_rstn) begin
				// Pulse running, new requests ignored
				if (count != '0)
					count <= count - 1'b1;
				else
					soft_rstn <= 1'b1;
			end else if (reset_done_q && !reset_done) begin
				// Request seen, go low next cycle
				soft_rstn <= 1'b0;
				count     <= SOFT_CNT_W'(SOFT_RST_CYCLES - 1);
			end
		end
	end

endmodule

// File: hw/status_reporter.sv
/*
 * Status reporter
 * Delivers the completion status to the host over
 * a four-phase req/ack, then acks the done controller
 */
`timescale 1ns/1ps

module status_reporter (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         report_req,
	input  logic [afu_pkg::STATUS_W-1:0] report_status,
	output logic                         report_ack,
	output logic                         status_req,
	input  logic                         status_ack,
	output logic [afu_pkg::STATUS_W-1:0] status_data
);

	typedef enum logic [1:0] {
		REP_IDLE, REP_WAIT_ACK, REP_WAIT_REL
	} rep_state_t;

	rep_state_t state;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= REP_IDLE;
			status_req <= 1'b0;
			report_ack <= 1'b0;
		end else begin
			report_ack <= 1'b0;
			case (state)
				// Skip the cycle our own ack is still out
				REP_IDLE: if (report_req && !report_ack) begin
					status_req <= 1'b1;
					state      <= REP_WAIT_ACK;
				end
				// Hold req and data until the host acks
				REP_WAIT_ACK: if (status_ack) begin
					status_req <= 1'b0;
					state      <= REP_WAIT_REL;
				end
				// Host must drop ack before the controller moves on
				REP_WAIT_REL: if (!status_ack) begin
					report_ack <= 1'b1;
					state      <= REP_IDLE;
				end
				default: state <= REP_IDLE;
			endcase
		end
	end

	// Data captured with req, stable through the handshake
	always_ff @(posedge clock) begin
		if (state == REP_IDLE && report_req && !report_ack)
			status_data <= report_status;
	end

endmodule

// File: hw/sum_sq_engine.sv
/*
 * Sum of squares engine
 * Adds k*k for k = 1..N into a 32-bit accumulator,
 * one term per clock, then holds result and done
 */
`timescale 1ns/1ps

module sum_sq_engine (
	input  logic     clock,
	input  logic     rstn,
	input  logic     soft_rstn,
	job_if.engine_mp job
);

	logic [15:0] count;
	logic [31:0] acc;
	logic [31:0] square;
	logic        running;
	logic        done_q;

	// 16x16 product always fits in 32 bits
	assign square = 32'(count) * 32'(count);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count   <= '0;
			acc     <= '0;
			running <= 1'b0;
			done_q  <= 1'b0;
		end else if (!soft_rstn || job.clear) begin
			// Soft reset wipes the finished job
			count   <= '0;
			acc     <= '0;
			running <= 1'b0;
			done_q  <= 1'b0;
		end else if (job.start) begin
			acc   <= '0;
			count <= 16'd1;
			// Empty job is done right away with sum 0
			if (job.length == 16'd0) begin
				running <= 1'b0;
				done_q  <= 1'b1;
			end else begin
				running <= 1'b1;
				done_q  <= 1'b0;
			end
		end else if (running) begin
			acc <= acc + square;
			// Last term added this cycle
			if (count == job.length) begin
				running <= 1'b0;
				done_q  <= 1'b1;
			end else begin
				count <= count + 16'd1;
			end
		end
	end

	// Result is only meaningful while done is high
	assign job.result = acc;
	assign job.done   = done_q;

endmodule

// File: tb/accel_assert.sv
/*
 * Handshake checks for the accelerator top
 * Command and status four-phase rules, status data hold
 */
`timescale 1ns/1ps

module accel_assert (
	input logic                         clock,
	input logic                         rstn,
	input logic                         cmd_req,
	input logic                         cmd_ack,
	input logic                         status_req,
	input logic                         status_ack,
	input logic [afu_pkg::STATUS_W-1:0] status_data,
	input logic                         busy
);

	// Read by the testbench top at the end of the run
	int fail_count = 0;

	////////////////////
	// Command side
	////////////////////

	// Ack only answers a pending request
	cmd_ack_rise: assert property (@(posedge clock) disable iff (!rstn)
		$rose(cmd_ack) |-> $past(cmd_req))
	else begin
		fail_count++;
		$error("cmd_ack rose while cmd_req was low");
	end

	// Ack released only after the host let go
	cmd_ack_fall: assert property (@(posedge clock) disable iff (!rstn)
		$fell(cmd_ack) |-> !$past(cmd_req))
	else begin
		fail_count++;
		$error("cmd_ack fell while cmd_req was still high");
	end

	// No job in flight right out of reset
	busy_after_reset: assert property (@(posedge clock)
		$rose(rstn) |-> !busy)
	else begin
		fail_count++;
		$error("busy was high after reset");
	end

	////////////////////
	// Status side
	////////////////////

	// Req held until the host acks
	status_req_hold: assert property (@(posedge clock) disable iff (!rstn)
		status_req && !status_ack |=> status_req)
	else begin
		fail_count++;
		$error("status_req dropped before status_ack");
	end

	status_data_hold: assert property (@(posedge clock) disable iff (!rstn)
		status_req && $past(status_req) |-> $stable(status_data))
	else begin
		fail_count++;
		$error("status_data changed while status_req was high");
	end

endmodule

// Checks sit on the top level handshake ports
bind accel_top accel_assert u_checks (
	.clock, .rstn, .cmd_req, .cmd_ack,
	.status_req, .status_ack, .status_data, .busy
);

// File: tb/accel_tb.sv
/*
 * Accelerator completion path testbench
 * Host side of both handshakes, sum of squares
 * reference model, per-test reports and watchdog
 */
`timescale 1ns/1ps

module accel_tb;
	import afu_pkg::*;

	// Job 0 fixed, 1..4 back to back, 5..7 for the later tests
	localparam int NUM_JOBS = 8;

	logic                clock;
	logic                rstn;
	logic                cmd_req;
	cmd_op_t             cmd_op;
	logic [31:0]         cmd_data;
	logic                cmd_ack;
	logic                status_req;
	logic                status_ack;
	logic [STATUS_W-1:0] status_data;
	logic                busy;

	logic [15:0] lengths [NUM_JOBS];
	logic [15:0] tags [NUM_JOBS];
	int          budget_cycles;
	bit          budget_ready;
	int          test_errors;
	int          tests_passed;
	int          tests_failed;

	tb_clock clk_gen (.clock, .rstn);

	accel_top uut (
		.clock, .rstn, .cmd_req, .cmd_op, .cmd_data, .cmd_ack,
		.status_req, .status_ack, .status_data, .busy
	);

	////////////////////
	// Reference model
	////////////////////

	// Sum of k*k for k = 1..n, wraps at 2^32
	function automatic logic [31:0] sum_of_squares(input logic [15:0] n);
		logic [31:0] acc;
		logic [31:0] k;
		acc = '0;
		for (k = 32'd1; k <= 32'(n); k++)
			acc = acc + k * k;
		return acc;
	endfunction

	// Tag, length, sum
	function automatic logic [STATUS_W-1:0] expected_status(input int idx);
		return {tags[idx], lengths[idx], sum_of_squares(lengths[idx])};
	endfunction

	////////////////////
	// Host tasks
	////////////////////

	task automatic send_command(input cmd_op_t op, input logic [31:0] data);
		@(negedge clock);
		cmd_op   = op;
		cmd_data = data;
		cmd_req  = 1'b1;
		while (!cmd_ack) @(negedge clock);
		cmd_req = 1'b0;
		while (cmd_ack) @(negedge clock);
		cmd_op = CMD_NOP;
	endtask

	// Take one status word, ack it late by ack_delay cycles, wait for the slot to free
	task automatic collect_status(input string name, input int idx, input int ack_delay);
		logic [STATUS_W-1:0] got;
		while (!status_req) @(negedge clock);
		got = status_data;
		repeat (ack_delay) @(negedge clock);
		status_ack = 1'b1;
		while (status_req) @(negedge clock);
		status_ack = 1'b0;
		if (got !== expected_status(idx)) begin
			$display("[FAIL] %s expected %h actual %h", name, expected_status(idx), got);
			test_errors++;
		end
		while (busy) @(negedge clock);
	endtask

	// No status request may show up for a while
	task automatic expect_quiet(input string name, input int cycles);
		bit seen;
		seen = 1'b0;
		repeat (cycles) begin
			@(negedge clock);
			seen = seen | status_req;
		end
		if (seen) begin
			$display("%s: the DUT raised status_req when no status was due", name);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errors == 0) begin
			$display("[PASS] %s", name);
			tests_passed++;
		end else begin
			$display("[DONE] %s with %0d failed check(s)", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		cmd_req      = 1'b0;
		cmd_op       = CMD_NOP;
		cmd_data     = '0;
		status_ack   = 1'b0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		budget_ready = 1'b0;
		void'($urandom(32'ha4b2_1b26));

		// Tags kept nonzero since an all-zero status is never reported
		lengths[0] = 16'd5;
		tags[0]    = 16'h5a05;
		for (int i = 1; i < NUM_JOBS; i++) begin
			lengths[i] = 16'($urandom % 201);
			tags[i]    = 16'(($urandom % 32'hffff) + 1);
		end
		lengths[4] = 16'd0;

		// Two passes per job length covers the disabled wait, plus fixed overhead
		budget_cycles = 1000;
		for (int i = 0; i < NUM_JOBS; i++)
			budget_cycles += 2 * int'(lengths[i]) + 100;
		budget_ready = 1'b1;

		wait (rstn);
		send_command(CMD_ENABLE, 32'd0);
		send_command(CMD_START, {tags[0], lengths[0]});
		collect_status("basic length 5", 0, 0);
		end_test("basic length 5");

		for (int i = 1; i <= 4; i++) begin
			send_command(CMD_START, {tags[i], lengths[i]});
			collect_status($sformatf("random job %0d", i), i, 0);
		end
		end_test("random back to back");

		// Second START lands while busy and must vanish
		send_command(CMD_START, {tags[5], lengths[5]});
		send_command(CMD_START, {~tags[5], lengths[5]});
		collect_status("start while busy", 5, 0);
		// Long enough for a wrongly started second job to report
		expect_quiet("start while busy", int'(lengths[5]) + 40);
		end_test("start while busy");

		send_command(CMD_DISABLE, 32'd0);
		send_command(CMD_START, {tags[6], lengths[6]});
		expect_quiet("disabled completion", int'(lengths[6]) + 30);
		if (busy !== 1'b1) begin
			$display("[FAIL] busy while disabled expected 1 actual %b", busy);
			test_errors++;
		end
		send_command(CMD_ENABLE, 32'd0);
		collect_status("disabled completion", 6, 0);
		end_test("disabled completion");

		send_command(CMD_START, {tags[7], lengths[7]});
		collect_status("late status ack", 7, 20);
		end_test("late status ack");

		$display("Tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, uut.u_checks.fail_count);
		if (tests_failed == 0 && uut.u_checks.fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	////////////////////
	// Watchdog
	////////////////////

	initial begin
		wait (budget_ready);
		repeat (budget_cycles) @(posedge clock);
		$display("Watchdog expired after %0d cycles, the DUT stopped answering", budget_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: tb/tb_clock.sv
/*
 * Testbench clock and reset
 * 100 ns clock, rstn low for the first 3 cycles
 */
`timescale 1ns/1ps

module tb_clock (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Released on a falling edge, away from the DUT's active edge
	initial begin
		rstn = 1'b0;
		repeat (3) @(negedge clock);
		rstn = 1'b1;
	end

endmodule
